// ==== rtl/snac_pkg.sv ====
// Controller codes, poll FSM states, data widths and poll strobe step constants
package snac_pkg;

    // Core master clock
    localparam int unsigned CLK_FREQ_HZ = 50_000_000;

    // Phase accumulator and step width
    localparam int unsigned STEP_W = 32;

    // Button word per player
    localparam int unsigned BTN_W = 16;

    // Bits shifted out of each pad per poll
    localparam int unsigned NES_BITS  = 8;
    localparam int unsigned SNES_BITS = 16;

    // Wide enough to count up to SNES_BITS
    localparam int unsigned BIT_CNT_W = 5;

    // Poll rate per pad type, the FSM runs one phase per strobe at twice this rate
    localparam int unsigned SNES_POLL_HZ = 50_000;
    localparam int unsigned NES_POLL_HZ  = 50_000;

    // Full scale of the accumulator, 2^STEP_W
    localparam logic [63:0] STEP_FULL_SCALE = 64'd1 << STEP_W;

    // step = 2^32 * 2 * poll rate / clock, one strobe per 500 clocks at 50 MHz
    localparam logic [STEP_W-1:0] SNES_STEP =
        STEP_W'((STEP_FULL_SCALE * 64'd2 * 64'(SNES_POLL_HZ)) / 64'(CLK_FREQ_HZ));
    localparam logic [STEP_W-1:0] NES_STEP =
        STEP_W'((STEP_FULL_SCALE * 64'd2 * 64'(NES_POLL_HZ)) / 64'(CLK_FREQ_HZ));

    // Controller type codes on the 5-bit settings bus
    // Codes not listed here are treated as disabled
    typedef enum logic [4:0] {
        GC_DISABLED = 5'd0,
        GC_NES      = 5'd2,
        GC_SNES     = 5'd3
    } ctrl_type_e;

    // Poll sequencer states
    // S_IDLE   waiting for a strobe with a serial pad type selected
    // S_LATCH  latch high, pads load their button state
    // S_READ   clock low, data line holds the current bit
    // S_CLK    clock high, pad moves to the next bit on the rising edge
    // S_DONE   all bits read, hand the words to the outputs
    typedef enum logic [2:0] {
        S_IDLE  = 3'd0,
        S_LATCH = 3'd1,
        S_READ  = 3'd2,
        S_CLK   = 3'd3,
        S_DONE  = 3'd4
    } poll_state_e;

endpackage

// ==== rtl/snac_mode_select.sv ====
// Controller type register with change detect restart and poll strobe step select
module snac_mode_select (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  snac_pkg::ctrl_type_e            i_ctrl_type,
    output snac_pkg::ctrl_type_e            o_ctrl_type,
    output logic                            o_restart,
    output logic [snac_pkg::STEP_W-1:0]     o_step
);

    // Registered type, restart flag and step all move on the same edge
    snac_pkg::ctrl_type_e               ctrl_type_q;
    logic                               restart_q;
    logic [snac_pkg::STEP_W-1:0]        step_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ctrl_type_q <= snac_pkg::GC_DISABLED;
            // Held high through reset so the poll path starts clean
            restart_q   <= 1'b1;
            step_q      <= '0;
        end else begin
            ctrl_type_q <= i_ctrl_type;
            // One cycle pulse on the edge where the new type is taken
            restart_q   <= (i_ctrl_type != ctrl_type_q);

            // Step follows the incoming type so it lines up with ctrl_type_q
            case (i_ctrl_type)
                snac_pkg::GC_SNES: begin
                    step_q <= snac_pkg::SNES_STEP;
                end
                snac_pkg::GC_NES: begin
                    step_q <= snac_pkg::NES_STEP;
                end
                default: begin
                    // Disabled or unknown, timer stops
                    step_q <= '0;
                end
            endcase
        end
    end

    assign o_ctrl_type = ctrl_type_q;
    assign o_restart   = restart_q;
    assign o_step      = step_q;

endmodule

// ==== rtl/poll_strobe_timer.sv ====
// Fractional phase accumulator producing one-cycle poll strobes from a step size
module poll_strobe_timer (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_restart,
    input  logic [snac_pkg::STEP_W-1:0]     i_step,
    output logic                            o_strobe
);

    // Accumulator phase
    logic [snac_pkg::STEP_W-1:0]    acc_q;
    // One extra bit for the carry out
    logic [snac_pkg::STEP_W:0]      acc_sum;
    logic                           strobe_q;

    assign acc_sum = {1'b0, acc_q} + {1'b0, i_step};

    always_ff @(posedge i_clk) begin
        if (i_reset || i_restart) begin
            acc_q    <= '0;
            strobe_q <= 1'b0;
        end else begin
            // Wraps modulo 2^STEP_W, a zero step never carries
            acc_q    <= acc_sum[snac_pkg::STEP_W-1:0];
            // Carry marks one strobe period
            strobe_q <= acc_sum[snac_pkg::STEP_W];
        end
    end

    assign o_strobe = strobe_q;

endmodule

// ==== rtl/serlatch_poll_fsm.sv ====
// Poll FSM driving pad latch and clock, bit sampling, capture and busy
module serlatch_poll_fsm (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_restart,
    input  logic                    i_strobe,
    input  snac_pkg::ctrl_type_e    i_ctrl_type,
    output logic                    o_latch,
    output logic                    o_clock,
    output logic                    o_sample,
    output logic                    o_capture,
    output logic                    o_busy
);

    snac_pkg::poll_state_e                  state_q;
    logic [snac_pkg::BIT_CNT_W-1:0]         bit_cnt_q;
    logic [snac_pkg::BIT_CNT_W-1:0]         last_bit;
    logic                                   pad_enabled;
    logic                                   latch_q;
    logic                                   clock_q;
    logic                                   sample_q;
    logic                                   capture_q;
    logic                                   busy_q;

    // Only the serial latch pads start a poll
    assign pad_enabled = (i_ctrl_type == snac_pkg::GC_NES) ||
                         (i_ctrl_type == snac_pkg::GC_SNES);

    // Index of the final bit for the selected pad
    always_comb begin
        if (i_ctrl_type == snac_pkg::GC_SNES) begin
            last_bit = snac_pkg::BIT_CNT_W'(snac_pkg::SNES_BITS - 1);
        end else begin
            last_bit = snac_pkg::BIT_CNT_W'(snac_pkg::NES_BITS - 1);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset || i_restart) begin
            state_q   <= snac_pkg::S_IDLE;
            bit_cnt_q <= '0;
            latch_q   <= 1'b0;
            clock_q   <= 1'b0;
            sample_q  <= 1'b0;
            capture_q <= 1'b0;
            busy_q    <= 1'b0;
        end else begin
            // Pulses last one cycle
            sample_q  <= 1'b0;
            capture_q <= 1'b0;

            // Busy falls on the edge where the capture block loads the outputs
            if (capture_q) begin
                busy_q <= 1'b0;
            end

            case (state_q)
                snac_pkg::S_IDLE: begin
                    if (i_strobe && pad_enabled) begin
                        // Pads load their buttons while latch is high
                        latch_q   <= 1'b1;
                        busy_q    <= 1'b1;
                        bit_cnt_q <= '0;
                        state_q   <= snac_pkg::S_LATCH;
                    end
                end
                snac_pkg::S_LATCH: begin
                    if (i_strobe) begin
                        // Bit 0 shows on the data lines after latch falls
                        latch_q <= 1'b0;
                        clock_q <= 1'b0;
                        state_q <= snac_pkg::S_READ;
                    end
                end
                snac_pkg::S_READ: begin
                    if (i_strobe) begin
                        sample_q <= 1'b1;
                        if (bit_cnt_q == last_bit) begin
                            state_q <= snac_pkg::S_DONE;
                        end else begin
                            // Rising clock moves the pads to the next bit
                            clock_q   <= 1'b1;
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            state_q   <= snac_pkg::S_CLK;
                        end
                    end
                end
                snac_pkg::S_CLK: begin
                    if (i_strobe) begin
                        clock_q <= 1'b0;
                        state_q <= snac_pkg::S_READ;
                    end
                end
                snac_pkg::S_DONE: begin
                    // Last sample lands this cycle, capture follows it
                    capture_q <= 1'b1;
                    state_q   <= snac_pkg::S_IDLE;
                end
                default: begin
                    state_q <= snac_pkg::S_IDLE;
                end
            endcase
        end
    end

    assign o_latch   = latch_q;
    assign o_clock   = clock_q;
    assign o_sample  = sample_q;
    assign o_capture = capture_q;
    assign o_busy    = busy_q;

endmodule

// ==== rtl/pad_button_capture.sv ====
// Two pad bit collectors with registered active-high button word outputs
module pad_button_capture (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_restart,
    input  logic                            i_sample,
    input  logic                            i_capture,
    input  logic                            i_dat1,
    input  logic                            i_dat2,
    output logic [snac_pkg::BTN_W-1:0]      o_p1_buttons,
    output logic [snac_pkg::BTN_W-1:0]      o_p2_buttons
);

    logic [snac_pkg::BTN_W-1:0]         p1_shift_q;
    logic [snac_pkg::BTN_W-1:0]         p2_shift_q;
    logic [snac_pkg::BTN_W-1:0]         p1_btn_q;
    logic [snac_pkg::BTN_W-1:0]         p2_btn_q;
    // Position of the next bit read in this poll
    logic [snac_pkg::BIT_CNT_W-1:0]     bit_idx_q;
    // One-hot write slot, empty once the index passes the word
    logic [snac_pkg::BTN_W-1:0]         bit_sel;

    assign bit_sel = snac_pkg::BTN_W'(1) << bit_idx_q;

    always_ff @(posedge i_clk) begin
        if (i_reset || i_restart) begin
            p1_shift_q <= '0;
            p2_shift_q <= '0;
            p1_btn_q   <= '0;
            p2_btn_q   <= '0;
            bit_idx_q  <= '0;
        end else if (i_capture) begin
            // Whole words move out together, then start empty
            p1_btn_q   <= p1_shift_q;
            p2_btn_q   <= p2_shift_q;
            p1_shift_q <= '0;
            p2_shift_q <= '0;
            bit_idx_q  <= '0;
        end else if (i_sample) begin
            // Pad data is active low, a set bit means pressed
            // Unread upper bits stay 0 on NES
            p1_shift_q <= p1_shift_q | (bit_sel & {snac_pkg::BTN_W{~i_dat1}});
            p2_shift_q <= p2_shift_q | (bit_sel & {snac_pkg::BTN_W{~i_dat2}});
            bit_idx_q  <= bit_idx_q + 1'b1;
        end
    end

    assign o_p1_buttons = p1_btn_q;
    assign o_p2_buttons = p2_btn_q;

endmodule

// ==== rtl/snac_pin_map.sv ====
// Configuration A cartridge pin registers and fixed pin direction controls
module snac_pin_map (
    input  logic            i_clk,
    input  logic            i_reset,
    input  logic            i_latch,
    input  logic            i_clock,
    input  logic [3:0]      i_cart_bk0_in,
    output logic            o_dat1,
    output logic            o_dat2,
    output logic [1:0]      o_cart_bk1_out,
    output logic            o_cart_pin30_out,
    output logic            o_cart_bk0_dir,
    output logic            o_cart_pin30_dir,
    output logic            o_cart_pin31_dir
);

    // Bank 0 pins 2 and 3 carry nothing for NES or SNES pads
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            // Idle data level is high, nothing pressed
            o_dat1           <= 1'b1;
            o_dat2           <= 1'b1;
            // Latch and clock held low
            o_cart_bk1_out   <= 2'b00;
            o_cart_pin30_out <= 1'b0;
        end else begin
            // IO3 is player 1 data, IN7 is player 2 data
            o_dat1           <= i_cart_bk0_in[0];
            o_dat2           <= i_cart_bk0_in[1];
            // OUT2 latch on bit 1, OUT1 clock on bit 0
            o_cart_bk1_out   <= {i_latch, i_clock};
            // IO5 repeats the clock for the second pad
            o_cart_pin30_out <= i_clock;
        end
    end

    // Bank 0 input
    assign o_cart_bk0_dir   = 1'b0;
    // Pin 30 output
    assign o_cart_pin30_dir = 1'b1;
    // Pin 31 input
    assign o_cart_pin31_dir = 1'b0;

endmodule

// ==== rtl/snac_adapter.sv ====
// Top level of the NES and SNES SNAC adapter connecting settings, timer, FSM, capture and pins
module snac_adapter (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  snac_pkg::ctrl_type_e            i_ctrl_type,
    input  logic [3:0]                      i_cart_bk0_in,
    output logic [snac_pkg::BTN_W-1:0]      o_p1_buttons,
    output logic [snac_pkg::BTN_W-1:0]      o_p2_buttons,
    output logic                            o_busy,
    output logic [1:0]                      o_cart_bk1_out,
    output logic                            o_cart_pin30_out,
    output logic                            o_cart_bk0_dir,
    output logic                            o_cart_pin30_dir,
    output logic                            o_cart_pin31_dir
);

    // Settings to timer and FSM
    snac_pkg::ctrl_type_e               ctrl_type;
    logic                               restart;
    logic [snac_pkg::STEP_W-1:0]        step;
    // Phase tick
    logic                               strobe;
    // FSM to pins and capture
    logic                               latch;
    logic                               clock;
    logic                               sample;
    logic                               capture;
    // Registered pad data
    logic                               dat1;
    logic                               dat2;

    snac_mode_select u_mode_select (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_ctrl_type (i_ctrl_type),
        .o_ctrl_type (ctrl_type),
        .o_restart   (restart),
        .o_step      (step)
    );

    poll_strobe_timer u_strobe_timer (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_restart (restart),
        .i_step    (step),
        .o_strobe  (strobe)
    );

    serlatch_poll_fsm u_poll_fsm (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_restart   (restart),
        .i_strobe    (strobe),
        .i_ctrl_type (ctrl_type),
        .o_latch     (latch),
        .o_clock     (clock),
        .o_sample    (sample),
        .o_capture   (capture),
        .o_busy      (o_busy)
    );

    pad_button_capture u_button_capture (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_restart    (restart),
        .i_sample     (sample),
        .i_capture    (capture),
        .i_dat1       (dat1),
        .i_dat2       (dat2),
        .o_p1_buttons (o_p1_buttons),
        .o_p2_buttons (o_p2_buttons)
    );

    snac_pin_map u_pin_map (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_latch          (latch),
        .i_clock          (clock),
        .i_cart_bk0_in    (i_cart_bk0_in),
        .o_dat1           (dat1),
        .o_dat2           (dat2),
        .o_cart_bk1_out   (o_cart_bk1_out),
        .o_cart_pin30_out (o_cart_pin30_out),
        .o_cart_bk0_dir   (o_cart_bk0_dir),
        .o_cart_pin30_dir (o_cart_pin30_dir),
        .o_cart_pin31_dir (o_cart_pin31_dir)
    );

endmodule

// ==== dv/serlatch_pad_model.sv ====
// Behavioral NES or SNES pad answering latch and clock with a settable button pattern
module serlatch_pad_model (
    input  logic    i_latch,
    input  logic    i_clock,
    output logic    o_data
);

    // Pressed buttons, bit k goes out as the k-th bit
    logic [15:0]    pattern;
    // Bit on the data line, 16 means past the end
    logic [4:0]     bit_idx;

    initial begin
        pattern = '0;
        bit_idx = 5'd0;
    end

    // Latch loads the buttons and rewinds to bit 0
    // Each rising clock edge with latch low moves to the next bit
    always @(posedge i_latch or posedge i_clock) begin
        if (i_latch) begin
            bit_idx = 5'd0;
        end else if (bit_idx != 5'd16) begin
            bit_idx = bit_idx + 5'd1;
        end
    end

    // Active low data, line idles high once the pattern runs out
    always_comb begin
        if (bit_idx < 5'd16) begin
            o_data = ~pattern[bit_idx[3:0]];
        end else begin
            o_data = 1'b1;
        end
    end

    task automatic set_pattern(input logic [15:0] buttons);
        pattern = buttons;
    endtask

endmodule

// ==== dv/snac_adapter_tb.sv ====
// SNAC adapter testbench with clock, reset, two pad models, directed poll tests and timeout
module snac_adapter_tb;

    // About 3 SNES polls at ~16.5k cycles and 3 NES polls at ~8.5k, plus idle tests and margin
    localparam int TIMEOUT_CYCLES = 400_000;

    logic                           i_clk;
    logic                           i_reset;
    snac_pkg::ctrl_type_e           i_ctrl_type;
    logic [3:0]                     i_cart_bk0_in;
    logic [snac_pkg::BTN_W-1:0]     o_p1_buttons;
    logic [snac_pkg::BTN_W-1:0]     o_p2_buttons;
    logic                           o_busy;
    logic [1:0]                     o_cart_bk1_out;
    logic                           o_cart_pin30_out;
    logic                           o_cart_bk0_dir;
    logic                           o_cart_pin30_dir;
    logic                           o_cart_pin31_dir;
    logic                           pad1_data;
    logic                           pad2_data;
    integer                         seed;
    int                             error_count;
    int                             check_count;
    int                             cycle_count = 0;

    // Unused bank 0 pins float high
    assign i_cart_bk0_in = {2'b11, pad2_data, pad1_data};

    snac_adapter DUT (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_ctrl_type      (i_ctrl_type),
        .i_cart_bk0_in    (i_cart_bk0_in),
        .o_p1_buttons     (o_p1_buttons),
        .o_p2_buttons     (o_p2_buttons),
        .o_busy           (o_busy),
        .o_cart_bk1_out   (o_cart_bk1_out),
        .o_cart_pin30_out (o_cart_pin30_out),
        .o_cart_bk0_dir   (o_cart_bk0_dir),
        .o_cart_pin30_dir (o_cart_pin30_dir),
        .o_cart_pin31_dir (o_cart_pin31_dir)
    );

    // Both pads share latch (bit 1) and clock (bit 0)
    serlatch_pad_model pad1 (
        .i_latch (o_cart_bk1_out[1]),
        .i_clock (o_cart_bk1_out[0]),
        .o_data  (pad1_data)
    );

    serlatch_pad_model pad2 (
        .i_latch (o_cart_bk1_out[1]),
        .i_clock (o_cart_bk1_out[0]),
        .o_data  (pad2_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // Run limit
    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: timeout after %0d cycles, a poll never finished", cycle_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Inputs change and outputs are read 1 unit after the rising edge
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge i_clk);
            #1;
        end
    endtask

    task automatic check_equal(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // New type plus time for the restart to reach the outputs
    task automatic set_type(input logic [4:0] code);
        i_ctrl_type = snac_pkg::ctrl_type_e'(code);
        wait_cycles(3);
    endtask

    // One full poll, busy rises then falls
    // Pin 30 repeats the pad clock on every cycle of the poll
    task automatic wait_poll_done();
        logic pin30_ok;
        pin30_ok = 1'b1;
        while (!o_busy) wait_cycles(1);
        while (o_busy) begin
            wait_cycles(1);
            pin30_ok = pin30_ok & (o_cart_pin30_out === o_cart_bk1_out[0]);
        end
        check_equal("pin30 repeats clock", 16'(pin30_ok), 16'h0001);
    endtask

    task automatic load_patterns(output logic [15:0] p1, output logic [15:0] p2);
        p1 = 16'($random(seed));
        p2 = 16'($random(seed));
        pad1.set_pattern(p1);
        pad2.set_pattern(p2);
    endtask

    task automatic test_reset_state();
        wait_cycles(2);
        check_equal("reset p1 buttons", o_p1_buttons, 16'h0000);
        check_equal("reset p2 buttons", o_p2_buttons, 16'h0000);
        check_equal("reset latch and clock", 16'(o_cart_bk1_out), 16'h0000);
        check_equal("reset pin30 clock", 16'(o_cart_pin30_out), 16'h0000);
        check_equal("reset busy", 16'(o_busy), 16'h0000);
        check_equal("bk0 direction", 16'(o_cart_bk0_dir), 16'h0000);
        check_equal("pin30 direction", 16'(o_cart_pin30_dir), 16'h0001);
        check_equal("pin31 direction", 16'(o_cart_pin31_dir), 16'h0000);
    endtask

    task automatic test_snes_poll();
        logic [15:0] p1;
        logic [15:0] p2;
        load_patterns(p1, p2);
        set_type(5'd3);
        wait_poll_done();
        wait_poll_done();
        // All 16 bits read, pressed reads back as 1
        check_equal("SNES p1 buttons", o_p1_buttons, p1);
        check_equal("SNES p2 buttons", o_p2_buttons, p2);
    endtask

    task automatic test_nes_poll();
        logic [15:0] p1;
        logic [15:0] p2;
        load_patterns(p1, p2);
        set_type(5'd2);
        wait_poll_done();
        wait_poll_done();
        // Only 8 bits read, upper byte zero
        check_equal("NES p1 buttons", o_p1_buttons, {8'h00, p1[7:0]});
        check_equal("NES p2 buttons", o_p2_buttons, {8'h00, p2[7:0]});
    endtask

    task automatic test_idle_type(input logic [4:0] code);
        logic latch_seen;
        logic busy_seen;
        latch_seen = 1'b0;
        busy_seen  = 1'b0;
        set_type(code);
        wait_cycles(2);
        repeat (3000) begin
            wait_cycles(1);
            latch_seen = latch_seen | o_cart_bk1_out[1];
            busy_seen  = busy_seen | o_busy;
        end
        check_equal("idle type latch seen", 16'(latch_seen), 16'h0000);
        check_equal("idle type busy seen", 16'(busy_seen), 16'h0000);
        check_equal("idle type p1 buttons", o_p1_buttons, 16'h0000);
        check_equal("idle type p2 buttons", o_p2_buttons, 16'h0000);
    endtask

    task automatic test_type_change();
        logic [15:0] p1;
        logic [15:0] p2;
        load_patterns(p1, p2);
        set_type(5'd3);
        wait_poll_done();
        check_equal("pre-switch SNES p1", o_p1_buttons, p1);
        // Switch while the next poll is running
        while (!o_busy) wait_cycles(1);
        load_patterns(p1, p2);
        set_type(5'd2);
        check_equal("switch clears p1", o_p1_buttons, 16'h0000);
        check_equal("switch clears p2", o_p2_buttons, 16'h0000);
        check_equal("switch drops busy", 16'(o_busy), 16'h0000);
        wait_poll_done();
        check_equal("post-switch NES p1", o_p1_buttons, {8'h00, p1[7:0]});
        check_equal("post-switch NES p2", o_p2_buttons, {8'h00, p2[7:0]});
    endtask

    initial begin
        seed        = 32'h778a;
        error_count = 0;
        check_count = 0;
        i_reset     = 1'b1;
        i_ctrl_type = snac_pkg::GC_DISABLED;
        repeat (5) @(posedge i_clk);
        #1;
        i_reset = 1'b0;

        test_reset_state();
        test_snes_poll();
        test_nes_poll();
        test_idle_type(5'd0);
        test_type_change();
        // Unknown code
        test_idle_type(5'd5);

        $display("Checks run %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== snac_adapter.f ====
rtl/snac_pkg.sv
rtl/snac_mode_select.sv
rtl/poll_strobe_timer.sv
rtl/serlatch_poll_fsm.sv
rtl/pad_button_capture.sv
rtl/snac_pin_map.sv
rtl/snac_adapter.sv
dv/serlatch_pad_model.sv
dv/snac_adapter_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SNAC adapter testbench with Verilator
rm -f sim.log
verilator --binary --timing --top-module snac_adapter_tb -f snac_adapter.f \
    -o snac_adapter_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/snac_adapter_sim > sim.log 2>&1
grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "Simulation ended early, see sim.log"; exit 1; }
echo "Simulation passed"
